// File: source/scc_consts.svh
`ifndef SCC_CONSTS_SVH
`define SCC_CONSTS_SVH

// write register indices, as held in the pointer
`define SCC_WR1 4'd1
`define SCC_WR2 4'd2
`define SCC_WR3 4'd3
`define SCC_WR5 4'd5
`define SCC_WR9 4'd9
`define SCC_WR15 4'd15

// wr0 command field, bits 5:3
`define SCC_CMD_RESET_EXT 3'd2
`define SCC_CMD_RX_FIRST 3'd4
`define SCC_CMD_RESET_TXIP 3'd5

// wr9 reset codes, bits 7:6
`define SCC_RST_HW 2'b11
`define SCC_RST_CHA 2'b10

// vector status codes, channel A sources only
`define SCC_VEC_RX 3'b110
`define SCC_VEC_TX 3'b100
`define SCC_VEC_EXT 3'b101
`define SCC_VEC_NONE 3'b011

// ext/status enables after a hardware reset
`define SCC_WR15_RESET 8'hF8

// clk cycles per serial bit, fixed baud
`define SCC_BIT_CLKS 8

`endif

// File: source/scc_pkg.sv
`default_nettype none

package scc_pkg;

	// one bus or register byte
	typedef logic [7:0] scc_byte_t;

	// register pointer, 0 to 15
	typedef logic [3:0] scc_rindex_t;

	// status field merged into the modified vector
	typedef logic [2:0] scc_vstat_t;

	// shared by transmitter and receiver
	typedef enum logic [1:0] {
		UART_IDLE,
		UART_START,
		UART_DATA,
		UART_STOP
	} scc_uart_state_t;

endpackage

`default_nettype wire

// File: source/scc_reg_file.sv
`timescale 1ns/1ns
`default_nettype none

`include "scc_consts.svh"

module scc_reg_file import scc_pkg::*; (
	input wire logic clk,
	input wire logic reset_hw,
	input wire logic i_cs,
	input wire logic i_we,
	input wire logic [1:0] i_rs,
	input wire scc_byte_t i_wdata,
	output scc_rindex_t o_rindex,
	output scc_byte_t o_wr1,
	output scc_byte_t o_wr2,
	output scc_byte_t o_wr3,
	output scc_byte_t o_wr5,
	output scc_byte_t o_wr15,
	output logic [5:0] o_wr9_low,
	output scc_byte_t o_tx_data,
	output logic o_tx_start,
	output logic o_rd_data_a,
	output logic o_cmd_reset_ext,
	output logic o_cmd_rx_first,
	output logic o_cmd_reset_txip,
	output logic o_reset_ch,
	output logic o_reset_all
);

	scc_rindex_t rindex;
	scc_rindex_t rindex_latch;
	logic wreg;
	logic wreg_a;
	logic wr_data_a;
	logic wr0_a;
	logic wr9_wr;

	// rs[1] picks data, rs[0] picks side A
	assign wreg = i_cs & i_we & ~i_rs[1];
	assign wreg_a = wreg & i_rs[0];
	assign wr_data_a = i_cs & i_we & (i_rs == 2'b11);
	assign o_rd_data_a = i_cs & ~i_we & (i_rs == 2'b11);

	// commands only through the channel A pointer-0 write
	assign wr0_a = wreg_a & (rindex == 4'd0);
	assign o_cmd_reset_ext = wr0_a & (i_wdata[5:3] == `SCC_CMD_RESET_EXT);
	assign o_cmd_rx_first = wr0_a & (i_wdata[5:3] == `SCC_CMD_RX_FIRST);
	assign o_cmd_reset_txip = wr0_a & (i_wdata[5:3] == `SCC_CMD_RESET_TXIP);

	// wr9 is shared, either side may reset
	assign wr9_wr = wreg & (rindex == `SCC_WR9);
	assign o_reset_all = wr9_wr & (i_wdata[7:6] == `SCC_RST_HW);
	assign o_reset_ch = o_reset_all | (wr9_wr & (i_wdata[7:6] == `SCC_RST_CHA));

	// pointer latch follows control accesses
	always_ff @(posedge clk or posedge reset_hw) begin
		if (reset_hw) begin
			rindex_latch <= '0;
		end else if (i_cs && !i_rs[1]) begin
			rindex_latch <= '0;
			if (i_we && rindex == 4'd0) begin
				rindex_latch[2:0] <= i_wdata[2:0];
				// point high command adds 8
				rindex_latch[3] <= (i_wdata[5:3] == 3'b001);
			end
		end
	end

	// decode pointer only moves between accesses
	always_ff @(posedge clk or posedge reset_hw) begin
		if (reset_hw) begin
			rindex <= '0;
		end else if (!i_cs) begin
			rindex <= rindex_latch;
		end
	end

	assign o_rindex = rindex;

	// wr1 keeps bits 5 and 2 over a channel reset
	always_ff @(posedge clk or posedge reset_hw) begin
		if (reset_hw) begin
			o_wr1 <= '0;
		end else if (o_reset_ch) begin
			o_wr1 <= {2'b00, o_wr1[5], 2'b00, o_wr1[2], 2'b00};
		end else if (wreg_a && rindex == `SCC_WR1) begin
			o_wr1 <= i_wdata;
		end
	end

	// vector base, reachable from both sides
	always_ff @(posedge clk or posedge reset_hw) begin
		if (reset_hw) begin
			o_wr2 <= '0;
		end else if (wreg && rindex == `SCC_WR2) begin
			o_wr2 <= i_wdata;
		end
	end

	always_ff @(posedge clk or posedge reset_hw) begin
		if (reset_hw) begin
			o_wr3 <= '0;
		end else if (wreg_a && rindex == `SCC_WR3) begin
			o_wr3 <= i_wdata;
		end
	end

	// wr5 bits 7 and 4:1 cleared on channel reset
	always_ff @(posedge clk or posedge reset_hw) begin
		if (reset_hw) begin
			o_wr5 <= '0;
		end else if (o_reset_ch) begin
			o_wr5 <= {1'b0, o_wr5[6:5], 4'b0000, o_wr5[0]};
		end else if (wreg_a && rindex == `SCC_WR5) begin
			o_wr5 <= i_wdata;
		end
	end

	// top bits of wr9 are the reset command, only low bits stored
	always_ff @(posedge clk or posedge reset_hw) begin
		if (reset_hw) begin
			o_wr9_low <= '0;
		end else if (o_reset_all) begin
			o_wr9_low <= '0;
		end else if (wr9_wr) begin
			o_wr9_low <= i_wdata[5:0];
		end
	end

	always_ff @(posedge clk or posedge reset_hw) begin
		if (reset_hw) begin
			o_wr15 <= `SCC_WR15_RESET;
		end else if (o_reset_all) begin
			o_wr15 <= `SCC_WR15_RESET;
		end else if (wreg_a && rindex == `SCC_WR15) begin
			o_wr15 <= i_wdata;
		end
	end

	// transmit byte
	always_ff @(posedge clk) begin
		if (wr_data_a) begin
			o_tx_data <= i_wdata;
		end
	end

	// start strobe lines up with the registered byte
	always_ff @(posedge clk or posedge reset_hw) begin
		if (reset_hw) begin
			o_tx_start <= 1'b0;
		end else begin
			o_tx_start <= wr_data_a;
		end
	end

endmodule

`default_nettype wire

// File: source/scc_irq.sv
`timescale 1ns/1ns
`default_nettype none

`include "scc_consts.svh"

module scc_irq import scc_pkg::*; (
	input wire logic clk,
	input wire logic reset_hw,
	input wire logic i_rx_valid,
	input wire logic i_rd_data_a,
	input wire logic i_tx_busy,
	input wire logic i_dcd,
	input wire scc_byte_t i_wr1,
	input wire scc_byte_t i_wr3,
	input wire scc_byte_t i_wr5,
	input wire logic [5:0] i_wr9_low,
	input wire scc_byte_t i_wr15,
	input wire logic i_cmd_reset_ext,
	input wire logic i_cmd_rx_first,
	input wire logic i_cmd_reset_txip,
	input wire logic i_reset_ch,
	input wire logic i_reset_all,
	output logic o_rx_avail,
	output logic o_dcd_status,
	output logic o_tx_empty,
	output logic [2:0] o_ip,
	output scc_vstat_t o_vstat,
	output logic o_irq_n
);

	logic rx_first;
	logic rx_ip;
	logic tx_busy_q;
	logic tx_ip;
	logic latch_open;
	logic dcd_latch;
	logic do_latch;
	logic ext_ip;

	// char available, dropped by a side A data read
	always_ff @(posedge clk or posedge reset_hw) begin
		if (reset_hw) begin
			o_rx_avail <= 1'b0;
		end else if (i_reset_all) begin
			o_rx_avail <= 1'b0;
		end else if (i_rx_valid) begin
			o_rx_avail <= 1'b1;
		end else if (i_rd_data_a) begin
			o_rx_avail <= 1'b0;
		end
	end

	// armed for the next char in first-char mode
	always_ff @(posedge clk or posedge reset_hw) begin
		if (reset_hw) begin
			rx_first <= 1'b1;
		end else if (i_reset_ch || i_cmd_rx_first) begin
			rx_first <= 1'b1;
		end else if (i_rd_data_a) begin
			rx_first <= 1'b0;
		end
	end

	// wr1 4:3 = 01 first char, 10 all chars
	assign rx_ip = i_wr3[0] & o_rx_avail & (i_wr1[3] ^ i_wr1[4]) & (i_wr1[4] | rx_first);

	// tx buffer empty interrupt on busy falling
	always_ff @(posedge clk or posedge reset_hw) begin
		if (reset_hw) begin
			tx_busy_q <= 1'b0;
			tx_ip <= 1'b0;
		end else begin
			tx_busy_q <= i_tx_busy;
			if (i_reset_ch || !i_wr5[3] || i_cmd_reset_txip) begin
				tx_ip <= 1'b0;
			end else if (i_tx_busy && !tx_busy_q) begin
				// busy rising means a data write was taken
				tx_ip <= 1'b0;
			end else if (!i_tx_busy && tx_busy_q && i_wr1[1]) begin
				tx_ip <= 1'b1;
			end
		end
	end

	assign o_tx_empty = ~i_tx_busy;

	// dcd change while latch open and enabled in wr15
	assign do_latch = latch_open & i_wr15[3] & (i_dcd != dcd_latch);

	// latch tracks dcd while open, freezes when it closes
	always_ff @(posedge clk or posedge reset_hw) begin
		if (reset_hw) begin
			latch_open <= 1'b1;
			dcd_latch <= 1'b0;
			ext_ip <= 1'b0;
		end else if (i_reset_all || i_cmd_reset_ext) begin
			// reopen on the present level
			latch_open <= 1'b1;
			dcd_latch <= i_dcd;
			ext_ip <= 1'b0;
		end else begin
			if (latch_open) begin
				dcd_latch <= i_dcd;
			end
			if (do_latch) begin
				latch_open <= 1'b0;
				ext_ip <= i_wr1[0];
			end
		end
	end

	// latched value only when ext/status watches dcd
	assign o_dcd_status = i_wr15[3] ? dcd_latch : i_dcd;

	assign o_ip = {rx_ip, tx_ip, ext_ip};

	// rx first, then tx, then ext
	always_comb begin
		if (rx_ip) begin
			o_vstat = `SCC_VEC_RX;
		end else if (tx_ip) begin
			o_vstat = `SCC_VEC_TX;
		end else if (ext_ip) begin
			o_vstat = `SCC_VEC_EXT;
		end else begin
			o_vstat = `SCC_VEC_NONE;
		end
	end

	// wr9 bit 3 is master enable
	assign o_irq_n = ~(i_wr9_low[3] & (|o_ip));

endmodule

`default_nettype wire

// File: source/scc_uart_tx.sv
`timescale 1ns/1ns
`default_nettype none

`include "scc_consts.svh"

module scc_uart_tx import scc_pkg::*; (
	input wire logic clk,
	input wire logic reset_hw,
	input wire logic i_start,
	input wire scc_byte_t i_data,
	output logic o_txd,
	output logic o_busy
);

	localparam int CNT_W = $clog2(`SCC_BIT_CLKS);
	localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(`SCC_BIT_CLKS - 1);

	scc_uart_state_t state;
	logic [CNT_W-1:0] clk_cnt;
	logic [2:0] bit_cnt;
	scc_byte_t shreg;
	logic bit_end;

	assign bit_end = (state != UART_IDLE) && (clk_cnt == CNT_LAST);

	// start bit, 8 data lsb first, one stop bit
	always_ff @(posedge clk or posedge reset_hw) begin
		if (reset_hw) begin
			state <= UART_IDLE;
			clk_cnt <= '0;
			bit_cnt <= '0;
			o_txd <= 1'b1;
		end else if (state == UART_IDLE) begin
			clk_cnt <= '0;
			// start while busy never gets here
			if (i_start) begin
				state <= UART_START;
				o_txd <= 1'b0;
			end
		end else if (!bit_end) begin
			clk_cnt <= clk_cnt + 1'b1;
		end else begin
			clk_cnt <= '0;
			case (state)
				UART_START: begin
					state <= UART_DATA;
					bit_cnt <= '0;
					o_txd <= shreg[0];
				end
				UART_DATA: begin
					if (bit_cnt == 3'd7) begin
						state <= UART_STOP;
						o_txd <= 1'b1;
					end else begin
						bit_cnt <= bit_cnt + 1'b1;
						o_txd <= shreg[0];
					end
				end
				default: begin
					state <= UART_IDLE;
				end
			endcase
		end
	end

	// shift out one bit per bit period
	always_ff @(posedge clk) begin
		if (state == UART_IDLE && i_start) begin
			shreg <= i_data;
		end else if (bit_end) begin
			shreg <= {1'b0, shreg[7:1]};
		end
	end

	assign o_busy = (state != UART_IDLE);

endmodule

`default_nettype wire

// File: source/scc_uart_rx.sv
`timescale 1ns/1ns
`default_nettype none

`include "scc_consts.svh"

module scc_uart_rx import scc_pkg::*; (
	input wire logic clk,
	input wire logic reset_hw,
	input wire logic i_rxd,
	output logic o_valid,
	output scc_byte_t o_data
);

	localparam int CNT_W = $clog2(`SCC_BIT_CLKS);
	localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(`SCC_BIT_CLKS - 1);
	localparam logic [CNT_W-1:0] CNT_HALF = CNT_W'(`SCC_BIT_CLKS / 2 - 1);

	scc_uart_state_t state;
	logic rxd_s1;
	logic rxd_s2;
	logic rxd_q;
	logic [CNT_W-1:0] clk_cnt;
	logic [2:0] bit_cnt;
	scc_byte_t shreg;
	logic sample;

	// two flop sync, third flop for the start edge
	always_ff @(posedge clk or posedge reset_hw) begin
		if (reset_hw) begin
			rxd_s1 <= 1'b1;
			rxd_s2 <= 1'b1;
			rxd_q <= 1'b1;
		end else begin
			rxd_s1 <= i_rxd;
			rxd_s2 <= rxd_s1;
			rxd_q <= rxd_s2;
		end
	end

	// after start midpoint, a full bit lands on each next midpoint
	assign sample = (clk_cnt == CNT_LAST);

	always_ff @(posedge clk or posedge reset_hw) begin
		if (reset_hw) begin
			state <= UART_IDLE;
			clk_cnt <= '0;
			bit_cnt <= '0;
			o_valid <= 1'b0;
		end else begin
			o_valid <= 1'b0;
			clk_cnt <= clk_cnt + 1'b1;
			case (state)
				UART_IDLE: begin
					clk_cnt <= '0;
					if (rxd_q && !rxd_s2) begin
						state <= UART_START;
					end
				end
				UART_START: begin
					if (clk_cnt == CNT_HALF) begin
						clk_cnt <= '0;
						bit_cnt <= '0;
						// still low at mid start, else a glitch
						state <= rxd_s2 ? UART_IDLE : UART_DATA;
					end
				end
				UART_DATA: begin
					if (sample) begin
						bit_cnt <= bit_cnt + 1'b1;
						if (bit_cnt == 3'd7) begin
							state <= UART_STOP;
						end
					end
				end
				default: begin
					if (sample) begin
						state <= UART_IDLE;
						// low stop bit drops the frame
						o_valid <= rxd_s2;
					end
				end
			endcase
		end
	end

	// lsb arrives first
	always_ff @(posedge clk) begin
		if (state == UART_DATA && sample) begin
			shreg <= {rxd_s2, shreg[7:1]};
		end
	end

	// holds last good char for data reads
	always_ff @(posedge clk) begin
		if (state == UART_STOP && sample && rxd_s2) begin
			o_data <= shreg;
		end
	end

endmodule

`default_nettype wire

// File: source/scc_top.sv
`timescale 1ns/1ns
`default_nettype none

module scc_top import scc_pkg::*; (
	input wire logic clk,
	input wire logic reset_hw,
	input wire logic i_cs,
	input wire logic i_we,
	input wire logic [1:0] i_rs,
	input wire scc_byte_t i_wdata,
	output scc_byte_t o_rdata,
	output logic o_irq_n,
	input wire logic i_rxd,
	output logic o_txd,
	output logic o_rts,
	input wire logic i_dcd
);

	scc_rindex_t rindex;
	scc_byte_t wr1;
	scc_byte_t wr2;
	scc_byte_t wr3;
	scc_byte_t wr5;
	scc_byte_t wr15;
	logic [5:0] wr9_low;
	scc_byte_t tx_data;
	logic tx_start;
	logic tx_busy;
	logic rd_data_a;
	logic cmd_reset_ext;
	logic cmd_rx_first;
	logic cmd_reset_txip;
	logic reset_ch;
	logic reset_all;
	logic rx_valid;
	scc_byte_t rx_data;
	logic rx_avail;
	logic dcd_status;
	logic tx_empty;
	logic [2:0] ip;
	scc_vstat_t vstat;
	scc_byte_t rr0;
	scc_byte_t rr1;
	scc_byte_t rr2_b;
	scc_byte_t rr3;
	scc_byte_t rr15;

	scc_reg_file reg_file0 (
		.clk(clk),
		.reset_hw(reset_hw),
		.i_cs(i_cs),
		.i_we(i_we),
		.i_rs(i_rs),
		.i_wdata(i_wdata),
		.o_rindex(rindex),
		.o_wr1(wr1),
		.o_wr2(wr2),
		.o_wr3(wr3),
		.o_wr5(wr5),
		.o_wr15(wr15),
		.o_wr9_low(wr9_low),
		.o_tx_data(tx_data),
		.o_tx_start(tx_start),
		.o_rd_data_a(rd_data_a),
		.o_cmd_reset_ext(cmd_reset_ext),
		.o_cmd_rx_first(cmd_rx_first),
		.o_cmd_reset_txip(cmd_reset_txip),
		.o_reset_ch(reset_ch),
		.o_reset_all(reset_all)
	);

	scc_irq irq0 (
		.clk(clk),
		.reset_hw(reset_hw),
		.i_rx_valid(rx_valid),
		.i_rd_data_a(rd_data_a),
		.i_tx_busy(tx_busy),
		.i_dcd(i_dcd),
		.i_wr1(wr1),
		.i_wr3(wr3),
		.i_wr5(wr5),
		.i_wr9_low(wr9_low),
		.i_wr15(wr15),
		.i_cmd_reset_ext(cmd_reset_ext),
		.i_cmd_rx_first(cmd_rx_first),
		.i_cmd_reset_txip(cmd_reset_txip),
		.i_reset_ch(reset_ch),
		.i_reset_all(reset_all),
		.o_rx_avail(rx_avail),
		.o_dcd_status(dcd_status),
		.o_tx_empty(tx_empty),
		.o_ip(ip),
		.o_vstat(vstat),
		.o_irq_n(o_irq_n)
	);

	scc_uart_tx uart_tx0 (
		.clk(clk),
		.reset_hw(reset_hw),
		.i_start(tx_start),
		.i_data(tx_data),
		.o_txd(o_txd),
		.o_busy(tx_busy)
	);

	scc_uart_rx uart_rx0 (
		.clk(clk),
		.reset_hw(reset_hw),
		.i_rxd(i_rxd),
		.o_valid(rx_valid),
		.o_data(rx_data)
	);

	// rts mirrors char available
	assign o_rts = rx_avail;

	// bit 6 underrun/eom, bit 5 cts taken from tx empty
	assign rr0 = {1'b0, 1'b1, tx_empty, 1'b0, dcd_status, tx_empty, 1'b0, rx_avail};

	// residue code 011, all sent
	assign rr1 = {5'b00000, 2'b11, tx_empty};

	// channel B pending bits always zero
	assign rr3 = {2'b00, ip, 3'b000};

	assign rr15 = {wr15[7:3], 1'b0, wr15[1], 1'b0};

	// status high puts the code reversed in 6:4
	assign rr2_b = wr9_low[4] ? {wr2[7], vstat[0], vstat[1], vstat[2], wr2[3:0]}
		: {wr2[7:4], vstat, wr2[0]};

	always_comb begin
		case (i_rs)
			2'b11: o_rdata = rx_data;
			2'b10: o_rdata = 8'hFF;
			2'b01: begin
				case (rindex)
					4'd0, 4'd4: o_rdata = rr0;
					4'd1, 4'd5: o_rdata = rr1;
					4'd2, 4'd6: o_rdata = wr2;
					4'd3, 4'd7: o_rdata = rr3;
					4'd11, 4'd15: o_rdata = rr15;
					default: o_rdata = 8'h00;
				endcase
			end
			default: begin
				// side B only has the modified vector
				if (rindex == 4'd2 || rindex == 4'd6) begin
					o_rdata = rr2_b;
				end else begin
					o_rdata = 8'hFF;
				end
			end
		endcase
	end

endmodule

`default_nettype wire

// File: verification/scc_props.sv
`timescale 1ns/1ns
`default_nettype none

`include "scc_consts.svh"

module scc_props import scc_pkg::*; (
	input wire logic clk,
	input wire logic reset_hw,
	input wire logic i_irq_n,
	input wire logic i_mie,
	input wire scc_vstat_t i_vstat,
	input wire logic i_txd,
	input wire logic i_tx_busy,
	input wire logic i_rts,
	input wire logic i_rx_valid
);

	// line low needs master enable and a source in the vector status
	irq_needs_mie: assert property (@(posedge clk) disable iff (reset_hw)
		(!i_mie || i_vstat == `SCC_VEC_NONE) |-> i_irq_n)
		else $error("o_irq_n low with master enable clear or no pending source");

	// line rests at mark between frames
	txd_idle_high: assert property (@(posedge clk) disable iff (reset_hw) !i_tx_busy |-> i_txd)
		else $error("o_txd low while transmitter idle");

	// rts only follows a received char
	rts_after_valid: assert property (@(posedge clk) disable iff (reset_hw)
		$rose(i_rts) |-> $past(i_rx_valid))
		else $error("o_rts rose without rx_valid");

endmodule

bind scc_top scc_props props0 (
	.clk(clk),
	.reset_hw(reset_hw),
	.i_irq_n(o_irq_n),
	.i_mie(wr9_low[3]),
	.i_vstat(vstat),
	.i_txd(o_txd),
	.i_tx_busy(tx_busy),
	.i_rts(o_rts),
	.i_rx_valid(rx_valid)
);

`default_nettype wire

// File: verification/scc_tb.sv
`timescale 1ns/1ns
`default_nettype none

`include "scc_consts.svh"

module scc_tb import scc_pkg::*; ();

	// rs[1] picks data, rs[0] picks side A
	localparam logic [1:0] RS_CTL_B = 2'b00;
	localparam logic [1:0] RS_CTL_A = 2'b01;
	localparam logic [1:0] RS_DATA_A = 2'b11;
	localparam int TIMEOUT_CYCLES = 400;

	logic clk = 1'b0;
	logic reset_hw;
	logic i_cs;
	logic i_we;
	logic [1:0] i_rs;
	scc_byte_t i_wdata;
	scc_byte_t o_rdata;
	logic o_irq_n;
	logic i_rxd;
	logic o_txd;
	logic o_rts;
	logic i_dcd;

	logic [31:0] lfsr_state;
	int test_errors;
	int total_errors;
	int pass_count;
	int fail_count;
	// register contents the tests rely on later
	scc_byte_t wr2_val;
	scc_byte_t wr15_val;

	// 4 ns period
	always #2 clk = ~clk;

	scc_top dut0 (
		.clk(clk),
		.reset_hw(reset_hw),
		.i_cs(i_cs),
		.i_we(i_we),
		.i_rs(i_rs),
		.i_wdata(i_wdata),
		.o_rdata(o_rdata),
		.o_irq_n(o_irq_n),
		.i_rxd(i_rxd),
		.o_txd(o_txd),
		.o_rts(o_rts),
		.i_dcd(i_dcd)
	);

	// galois form, taps 32 22 2 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		if (s[0]) begin
			return (s >> 1) ^ 32'h8020_0003;
		end
		return s >> 1;
	endfunction

	// one lfsr step per bit
	task automatic random_byte(output scc_byte_t b);
		for (int i = 0; i < 8; i++) begin
			lfsr_state = lfsr_next(lfsr_state);
			b[i] = lfsr_state[0];
		end
	endtask

	// rr0 layout, bits 0 2 3 5 6
	function automatic scc_byte_t rr0_expect(input logic avail, input logic empty,
		input logic dcd);
		scc_byte_t v;
		v = 8'h00;
		v[0] = avail;
		v[2] = empty;
		v[3] = dcd;
		v[5] = empty;
		v[6] = 1'b1;
		return v;
	endfunction

	// status high: code reversed in 6:4, else in order in 3:1
	function automatic scc_byte_t vector_expect(input scc_byte_t base, input logic status_high,
		input scc_vstat_t code);
		scc_byte_t v;
		v = base;
		if (status_high) begin
			v[6] = code[0];
			v[5] = code[1];
			v[4] = code[2];
		end else begin
			v[3:1] = code;
		end
		return v;
	endfunction

	task automatic check_byte(input string name, input scc_byte_t expected,
		input scc_byte_t actual);
		if (actual !== expected) begin
			$display("** Error at %0t ns: %s expected %02h got %02h", $time, name,
				expected, actual);
			test_errors++;
		end
	endtask

	task automatic check_vstat(input string name, input scc_vstat_t expected,
		input scc_vstat_t actual);
		if (actual !== expected) begin
			$display("** Error at %0t ns: %s expected %03b got %03b", $time, name,
				expected, actual);
			test_errors++;
		end
	endtask

	task automatic check_bit(input string name, input logic expected, input logic actual);
		if (actual !== expected) begin
			$display("** Error at %0t ns: %s expected %b got %b", $time, name,
				expected, actual);
			test_errors++;
		end
	endtask

	task automatic report_timeout(input string what);
		$display("timeout at %0t ns, no %s within %0d cycles", $time, what, TIMEOUT_CYCLES);
		test_errors++;
	endtask

	task automatic end_test(input string name);
		total_errors += test_errors;
		if (test_errors == 0) begin
			pass_count++;
			$display("%s: pass", name);
		end else begin
			fail_count++;
			$display("%s: FAIL with %0d errors", name, test_errors);
		end
		test_errors = 0;
	endtask

	// one clk access, then an idle cycle so the pointer settles
	task automatic bus_write(input logic [1:0] rs, input scc_byte_t data);
		@(posedge clk);
		i_cs <= 1'b1;
		i_we <= 1'b1;
		i_rs <= rs;
		i_wdata <= data;
		@(posedge clk);
		i_cs <= 1'b0;
		i_we <= 1'b0;
		@(posedge clk);
	endtask

	// read data is combinational, taken mid access
	task automatic bus_read(input logic [1:0] rs, output scc_byte_t data);
		@(posedge clk);
		i_cs <= 1'b1;
		i_we <= 1'b0;
		i_rs <= rs;
		@(negedge clk);
		data = o_rdata;
		@(posedge clk);
		i_cs <= 1'b0;
		@(posedge clk);
	endtask

	// pointer values 8..15 carry the point high code in 5:3
	task automatic write_reg(input scc_rindex_t idx, input scc_byte_t val);
		bus_write(RS_CTL_A, {4'h0, idx});
		bus_write(RS_CTL_A, val);
	endtask

	task automatic read_reg(input logic [1:0] rs, input scc_rindex_t idx,
		output scc_byte_t data);
		bus_write(rs, {4'h0, idx});
		bus_read(rs, data);
	endtask

	task automatic send_command(input logic [2:0] code);
		bus_write(RS_CTL_A, {2'b00, code, 3'b000});
	endtask

	// 8n1 frame onto i_rxd, lsb first
	task automatic serial_send(input scc_byte_t data);
		logic [9:0] frame;
		frame = {1'b1, data, 1'b0};
		for (int i = 0; i < 10; i++) begin
			@(posedge clk);
			i_rxd <= frame[i];
			repeat (`SCC_BIT_CLKS - 1) @(posedge clk);
		end
		@(posedge clk);
	endtask

	// find start edge, then sample near each bit center
	task automatic serial_capture(output scc_byte_t data);
		int n;
		n = 0;
		data = '0;
		do begin
			@(negedge clk);
			n++;
		end while (o_txd !== 1'b0 && n < TIMEOUT_CYCLES);
		if (o_txd !== 1'b0) begin
			report_timeout("start bit on o_txd");
		end else begin
			repeat (`SCC_BIT_CLKS / 2) @(negedge clk);
			check_bit("o_txd start bit", 1'b0, o_txd);
			for (int i = 0; i < 8; i++) begin
				repeat (`SCC_BIT_CLKS) @(negedge clk);
				data[i] = o_txd;
			end
			repeat (`SCC_BIT_CLKS) @(negedge clk);
			check_bit("o_txd stop bit", 1'b1, o_txd);
		end
	endtask

	task automatic wait_irq(input logic level);
		int n;
		n = 0;
		do begin
			@(negedge clk);
			n++;
		end while (o_irq_n !== level && n < TIMEOUT_CYCLES);
		if (o_irq_n !== level) begin
			report_timeout("change on o_irq_n");
		end
	endtask

	task automatic wait_rts();
		int n;
		n = 0;
		do begin
			@(negedge clk);
			n++;
		end while (o_rts !== 1'b1 && n < TIMEOUT_CYCLES);
		if (o_rts !== 1'b1) begin
			report_timeout("rise on o_rts");
		end
	endtask

	// poll rr0 tx empty, three cycles per read
	task automatic wait_tx_empty();
		scc_byte_t rr0;
		int n;
		n = 0;
		do begin
			bus_read(RS_CTL_A, rr0);
			n += 3;
		end while (rr0[2] !== 1'b1 && n < TIMEOUT_CYCLES);
		if (rr0[2] !== 1'b1) begin
			report_timeout("tx empty in RR0");
		end
	endtask

	task automatic transmit_byte(input scc_byte_t b);
		scc_byte_t got;
		bus_write(RS_DATA_A, b);
		serial_capture(got);
		check_byte("o_txd frame", b, got);
		wait_tx_empty();
	endtask

	task automatic test_reset_state();
		scc_byte_t v;
		bus_read(RS_CTL_A, v);
		check_byte("RR0", rr0_expect(1'b0, 1'b1, 1'b0), v);
		read_reg(RS_CTL_A, `SCC_WR15, v);
		check_byte("RR15", `SCC_WR15_RESET & 8'hFA, v);
		read_reg(RS_CTL_A, 4'd1, v);
		check_byte("RR1", 8'h07, v);
		check_bit("o_irq_n", 1'b1, o_irq_n);
		check_bit("o_txd", 1'b1, o_txd);
		check_bit("o_rts", 1'b0, o_rts);
		end_test("reset state");
	endtask

	task automatic test_pointer();
		scc_byte_t v;
		random_byte(wr2_val);
		random_byte(wr15_val);
		write_reg(`SCC_WR2, wr2_val);
		write_reg(`SCC_WR15, wr15_val);
		read_reg(RS_CTL_A, `SCC_WR2, v);
		check_byte("RR2 side A", wr2_val, v);
		read_reg(RS_CTL_A, `SCC_WR15, v);
		check_byte("RR15", wr15_val & 8'hFA, v);
		// pointer back at 0 after the last access
		bus_read(RS_CTL_A, v);
		check_byte("RR0 after access", rr0_expect(1'b0, 1'b1, 1'b0), v);
		end_test("pointer protocol");
	endtask

	task automatic test_transmit();
		scc_byte_t b;
		scc_byte_t v;
		write_reg(`SCC_WR1, 8'h02);
		write_reg(`SCC_WR5, 8'h08);
		write_reg(`SCC_WR9, 8'h08);
		check_bit("o_irq_n before frame", 1'b1, o_irq_n);
		random_byte(b);
		transmit_byte(b);
		wait_irq(1'b0);
		bus_read(RS_CTL_A, v);
		check_byte("RR0 after frame", rr0_expect(1'b0, 1'b1, 1'b0), v);
		read_reg(RS_CTL_B, `SCC_WR2, v);
		check_vstat("vector status", `SCC_VEC_TX, v[3:1]);
		check_byte("modified vector", vector_expect(wr2_val, 1'b0, `SCC_VEC_TX), v);
		send_command(`SCC_CMD_RESET_TXIP);
		check_bit("o_irq_n after command 5", 1'b1, o_irq_n);
		end_test("transmit");
	endtask

	task automatic test_receive();
		scc_byte_t b;
		scc_byte_t v;
		write_reg(`SCC_WR3, 8'h01);
		// all-char mode, wr1 4:3 = 10
		write_reg(`SCC_WR1, 8'h10);
		random_byte(b);
		serial_send(b);
		wait_rts();
		bus_read(RS_CTL_A, v);
		check_byte("RR0 char available", rr0_expect(1'b1, 1'b1, 1'b0), v);
		check_bit("o_rts", 1'b1, o_rts);
		check_bit("o_irq_n", 1'b0, o_irq_n);
		read_reg(RS_CTL_B, `SCC_WR2, v);
		check_vstat("vector status", `SCC_VEC_RX, v[3:1]);
		check_byte("modified vector", vector_expect(wr2_val, 1'b0, `SCC_VEC_RX), v);
		bus_read(RS_DATA_A, v);
		check_byte("rx data", b, v);
		bus_read(RS_CTL_A, v);
		check_byte("RR0 after data read", rr0_expect(1'b0, 1'b1, 1'b0), v);
		check_bit("o_irq_n after data read", 1'b1, o_irq_n);
		check_bit("o_rts after data read", 1'b0, o_rts);
		end_test("receive");
	endtask

	task automatic test_dcd();
		scc_byte_t v;
		wr15_val = 8'h08;
		write_reg(`SCC_WR15, wr15_val);
		write_reg(`SCC_WR1, 8'h01);
		// status high this time
		write_reg(`SCC_WR9, 8'h18);
		@(posedge clk);
		i_dcd <= 1'b1;
		wait_irq(1'b0);
		read_reg(RS_CTL_A, 4'd3, v);
		check_byte("RR3 ext pending", 8'h08, v);
		@(posedge clk);
		i_dcd <= 1'b0;
		// latch closed, rr0 still shows the captured level
		bus_read(RS_CTL_A, v);
		check_byte("RR0 latched dcd", rr0_expect(1'b0, 1'b1, 1'b1), v);
		read_reg(RS_CTL_B, `SCC_WR2, v);
		check_vstat("vector status", `SCC_VEC_EXT, {v[4], v[5], v[6]});
		check_byte("modified vector", vector_expect(wr2_val, 1'b1, `SCC_VEC_EXT), v);
		send_command(`SCC_CMD_RESET_EXT);
		read_reg(RS_CTL_A, 4'd3, v);
		check_byte("RR3 after command 2", 8'h00, v);
		check_bit("o_irq_n after command 2", 1'b1, o_irq_n);
		bus_read(RS_CTL_A, v);
		check_byte("RR0 reopened latch", rr0_expect(1'b0, 1'b1, 1'b0), v);
		end_test("dcd ext/status");
	endtask

	task automatic test_channel_reset();
		scc_byte_t b;
		scc_byte_t v;
		write_reg(`SCC_WR1, 8'hFF);
		// channel reset, master enable kept set
		write_reg(`SCC_WR9, 8'h88);
		read_reg(RS_CTL_A, `SCC_WR2, v);
		check_byte("RR2 side A after reset", wr2_val, v);
		read_reg(RS_CTL_A, `SCC_WR15, v);
		check_byte("RR15 after reset", wr15_val & 8'hFA, v);
		// wr5 bit 3 was cleared, wr1 bit 1 stays cleared
		write_reg(`SCC_WR5, 8'h08);
		random_byte(b);
		transmit_byte(b);
		check_bit("o_irq_n after frame", 1'b1, o_irq_n);
		read_reg(RS_CTL_A, 4'd3, v);
		check_byte("RR3 after frame", 8'h00, v);
		write_reg(`SCC_WR9, 8'hC0);
		read_reg(RS_CTL_A, `SCC_WR15, v);
		check_byte("RR15 after hw reset", `SCC_WR15_RESET & 8'hFA, v);
		end_test("channel reset");
	endtask

	initial begin
		reset_hw = 1'b1;
		i_cs = 1'b0;
		i_we = 1'b0;
		i_rs = 2'b00;
		i_wdata = 8'h00;
		i_rxd = 1'b1;
		i_dcd = 1'b0;
		lfsr_state = 32'h9050_cf49;
		test_errors = 0;
		total_errors = 0;
		pass_count = 0;
		fail_count = 0;
		wr2_val = 8'h00;
		wr15_val = `SCC_WR15_RESET;
		repeat (3) @(posedge clk);
		reset_hw <= 1'b0;
		@(posedge clk);
		test_reset_state();
		test_pointer();
		test_transmit();
		test_receive();
		test_dcd();
		test_channel_reset();
		$display("tests: %0d pass, %0d fail, %0d wrong checks", pass_count, fail_count,
			total_errors);
		if (fail_count == 0 && total_errors == 0) begin
			$display("Test passed");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: filelist.f
+incdir+source
source/scc_pkg.sv
source/scc_reg_file.sv
source/scc_irq.sv
source/scc_uart_tx.sv
source/scc_uart_rx.sv
source/scc_top.sv
verification/scc_props.sv
verification/scc_tb.sv

// File: Makefile
# Verilator build and run for the SCC testbench

TOP := scc_tb

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -Wno-fatal -f filelist.f --top-module $(TOP)

run: build
	./obj_dir/V$(TOP) | tee run.log
	grep -q "^Test passed$$" run.log

lint:
	verilator --lint-only --timing -Wall -f filelist.f --top-module $(TOP)

clean:
	rm -rf obj_dir run.log
